/* verilog/rv_consts.svh */
// rv64 core constants
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN        64
`define RV_ILEN        32
`define RV_RIDX_W      5
`define RV_NREGS       32
`define RV_RESET_PC    64'h0000_0000_8000_0000

// major opcodes
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_OP      7'b0110011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_BRANCH  7'b1100011

// funct3 / funct7
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLT      3'b010
`define RV_F3_XOR      3'b100
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111
`define RV_F3_BEQ      3'b000
`define RV_F3_BNE      3'b001
`define RV_F7_SUB      7'b0100000

`endif

/* verilog/rv_pkg.sv */
// rv64 core types
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   xlen_t;
  typedef logic [`RV_ILEN-1:0]   inst_t;
  typedef logic [`RV_RIDX_W-1:0] ridx_t;

  // execute operation
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B,
    ALU_NONE
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_JAL,
    BR_BEQ,
    BR_BNE
  } br_kind_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT_DONE
  } fetch_state_e;

endpackage

`default_nettype wire

/* verilog/rv_pipe_ifs.sv */
// stage to stage interfaces
`timescale 1ns/1ps
`default_nettype none

// decode -> execute
interface dec_ex_if;
  import rv_pkg::*;

  logic     valid;
  xlen_t    pc;
  inst_t    inst;
  xlen_t    op_a;
  xlen_t    op_b;
  xlen_t    imm;
  ridx_t    rd;
  logic     rd_wen;
  alu_op_e  alu_op;
  br_kind_e br_kind;

  modport source (output valid, pc, inst, op_a, op_b, imm, rd, rd_wen, alu_op, br_kind);
  modport sink   (input  valid, pc, inst, op_a, op_b, imm, rd, rd_wen, alu_op, br_kind);
endinterface

// execute -> writeback
interface ex_wb_if;
  import rv_pkg::*;

  logic  valid;
  xlen_t pc;
  inst_t inst;
  ridx_t rd;
  logic  rd_wen;
  xlen_t rd_wdata;

  modport source (output valid, pc, inst, rd, rd_wen, rd_wdata);
  modport sink   (input  valid, pc, inst, rd, rd_wen, rd_wdata);
endinterface

`default_nettype wire

/* verilog/rv_fetch.sv */
// instruction fetch
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_fetch (
  input  wire           clk,
  input  wire           i_rst,
  input  wire           i_fetch_ready,
  input  rv_pkg::inst_t i_fetch_inst,
  input  wire           i_redirect,
  input  rv_pkg::xlen_t i_redirect_pc,
  input  wire           i_retired,
  output logic          o_fetch_valid,
  output rv_pkg::xlen_t o_fetch_pc,
  output logic          o_fetched,
  output rv_pkg::inst_t o_inst
);
  import rv_pkg::*;

  fetch_state_e state;
  xlen_t        pc;
  logic         redir_pend;
  xlen_t        redir_pc;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state      <= FETCH_IDLE;
      pc         <= `RV_RESET_PC;
      redir_pend <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: state <= FETCH_REQ;
        FETCH_REQ: begin
          if (i_fetch_ready) begin
            state <= FETCH_WAIT_DONE;
          end
        end
        FETCH_WAIT_DONE: begin
          if (i_redirect) begin
            redir_pend <= 1'b1;
          end
          // one instruction in flight so move on once it retires
          if (i_retired) begin
            state      <= FETCH_REQ;
            redir_pend <= 1'b0;
            if (redir_pend) begin
              pc <= redir_pc;
            end else begin
              pc <= pc + 64'd4;
            end
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // target held until retirement
  always_ff @(posedge clk) begin
    if (i_redirect) begin
      redir_pc <= i_redirect_pc;
    end
  end

  assign o_fetch_valid = (state == FETCH_REQ);
  assign o_fetch_pc    = pc;
  assign o_fetched     = o_fetch_valid & i_fetch_ready;
  assign o_inst        = i_fetch_inst;

  // request held while the responder stalls
  a_req_stable: assert property (@(posedge clk) disable iff (i_rst)
    o_fetch_valid && !i_fetch_ready |=> o_fetch_valid && $stable(o_fetch_pc))
    else $error("fetch request changed while waiting");

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
// instruction decode
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_decode (
  input  wire           clk,
  input  wire           i_rst,
  input  wire           i_fetched,
  input  rv_pkg::xlen_t i_pc,
  input  rv_pkg::inst_t i_inst,
  output rv_pkg::ridx_t o_rs1,
  output rv_pkg::ridx_t o_rs2,
  input  rv_pkg::xlen_t i_rs1_data,
  input  rv_pkg::xlen_t i_rs2_data,
  dec_ex_if.source      dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  ridx_t      rd;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm_b;
  xlen_t      imm;
  logic       use_imm;
  logic       rd_wen;
  alu_op_e    alu_op;
  br_kind_e   br_kind;

  assign opcode = i_inst[6:0];
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};

  always_comb begin
    alu_op  = ALU_NONE;
    br_kind = BR_NONE;
    use_imm = 1'b0;
    imm     = imm_i;
    rd_wen  = 1'b0;
    case (opcode)
      `RV_OPC_OP_IMM: begin
        // addi only
        if (funct3 == `RV_F3_ADD_SUB) begin
          alu_op  = ALU_ADD;
          use_imm = 1'b1;
          rd_wen  = 1'b1;
        end
      end
      `RV_OPC_OP: begin
        rd_wen = 1'b1;
        case (funct3)
          `RV_F3_ADD_SUB: alu_op = (funct7 == `RV_F7_SUB) ? ALU_SUB : ALU_ADD;
          `RV_F3_SLT:     alu_op = ALU_SLT;
          `RV_F3_XOR:     alu_op = ALU_XOR;
          `RV_F3_OR:      alu_op = ALU_OR;
          `RV_F3_AND:     alu_op = ALU_AND;
          default:        rd_wen = 1'b0;
        endcase
      end
      `RV_OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u;
        rd_wen  = 1'b1;
      end
      `RV_OPC_JAL: begin
        br_kind = BR_JAL;
        imm     = imm_j;
        rd_wen  = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        imm = imm_b;
        if (funct3 == `RV_F3_BEQ) begin
          br_kind = BR_BEQ;
        end else if (funct3 == `RV_F3_BNE) begin
          br_kind = BR_BNE;
        end
      end
      default: ;
    endcase
    // x0 is never written
    if (rd == '0) begin
      rd_wen = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= i_fetched;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      dec.pc      <= i_pc;
      dec.inst    <= i_inst;
      dec.op_a    <= i_rs1_data;
      dec.op_b    <= use_imm ? imm : i_rs2_data;
      dec.imm     <= imm;
      dec.rd      <= rd;
      dec.rd_wen  <= rd_wen;
      dec.alu_op  <= alu_op;
      dec.br_kind <= br_kind;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
// integer register file
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_regfile (
  input  wire           clk,
  input  wire           i_rst,
  input  rv_pkg::ridx_t i_rs1,
  input  rv_pkg::ridx_t i_rs2,
  output rv_pkg::xlen_t o_rs1_data,
  output rv_pkg::xlen_t o_rs2_data,
  input  rv_pkg::ridx_t i_rd,
  input  wire           i_rd_wen,
  input  rv_pkg::xlen_t i_rd_wdata
);
  import rv_pkg::*;

  // x0 has no storage
  xlen_t regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd != '0) begin
      regs[i_rd] <= i_rd_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // decode already drops rd == 0 writes
  a_no_x0_write: assert property (@(posedge clk) disable iff (i_rst)
    i_rd_wen |-> i_rd != '0)
    else $error("register write to x0");

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
// alu and branch resolution
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire           clk,
  input  wire           i_rst,
  dec_ex_if.sink        dec,
  ex_wb_if.source       wb,
  output logic          o_redirect,
  output rv_pkg::xlen_t o_redirect_pc
);
  import rv_pkg::*;

  xlen_t alu_res;
  xlen_t link_pc;
  xlen_t target;
  xlen_t result;
  logic  ops_eq;
  logic  taken;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_res = dec.op_a + dec.op_b;
      ALU_SUB:    alu_res = dec.op_a - dec.op_b;
      ALU_AND:    alu_res = dec.op_a & dec.op_b;
      ALU_OR:     alu_res = dec.op_a | dec.op_b;
      ALU_XOR:    alu_res = dec.op_a ^ dec.op_b;
      ALU_SLT:    alu_res = {63'b0, $signed(dec.op_a) < $signed(dec.op_b)};
      // lui
      ALU_PASS_B: alu_res = dec.op_b;
      default:    alu_res = '0;
    endcase
  end

  assign ops_eq  = (dec.op_a == dec.op_b);
  assign link_pc = dec.pc + 64'd4;
  assign target  = dec.pc + dec.imm;

  always_comb begin
    case (dec.br_kind)
      BR_JAL:  taken = 1'b1;
      BR_BEQ:  taken = ops_eq;
      BR_BNE:  taken = !ops_eq;
      default: taken = 1'b0;
    endcase
  end

  assign result = (dec.br_kind == BR_JAL) ? link_pc : alu_res;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wb.valid   <= 1'b0;
      o_redirect <= 1'b0;
    end else begin
      wb.valid   <= dec.valid;
      o_redirect <= dec.valid & taken;
    end
  end

  always_ff @(posedge clk) begin
    if (dec.valid) begin
      wb.pc         <= dec.pc;
      wb.inst       <= dec.inst;
      wb.rd         <= dec.rd;
      wb.rd_wen     <= dec.rd_wen;
      wb.rd_wdata   <= result;
      o_redirect_pc <= target;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_writeback.sv */
// writeback and commit record
`timescale 1ns/1ps
`default_nettype none

module rv_writeback (
  input  wire           clk,
  input  wire           i_rst,
  ex_wb_if.sink         wb,
  output rv_pkg::ridx_t o_rd,
  output logic          o_rd_wen,
  output rv_pkg::xlen_t o_rd_wdata,
  output logic          o_retired,
  output logic          o_cmt_valid,
  output rv_pkg::xlen_t o_cmt_pc,
  output rv_pkg::inst_t o_cmt_inst,
  output rv_pkg::ridx_t o_cmt_rd,
  output logic          o_cmt_wen,
  output rv_pkg::xlen_t o_cmt_wdata
);
  import rv_pkg::*;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_cmt_valid <= 1'b0;
    end else begin
      o_cmt_valid <= wb.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wb.valid) begin
      o_cmt_pc    <= wb.pc;
      o_cmt_inst  <= wb.inst;
      o_cmt_rd    <= wb.rd;
      o_cmt_wen   <= wb.rd_wen;
      o_cmt_wdata <= wb.rd_wdata;
    end
  end

  // regfile write lands in the commit cycle
  assign o_rd       = o_cmt_rd;
  assign o_rd_wen   = o_cmt_valid & o_cmt_wen;
  assign o_rd_wdata = o_cmt_wdata;
  assign o_retired  = o_cmt_valid;

  a_cmt_pulse: assert property (@(posedge clk) disable iff (i_rst)
    o_cmt_valid |=> !o_cmt_valid)
    else $error("commit strobe held for two cycles");

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
// rv64 core top
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire           clk,
  input  wire           i_rst,
  // fetch port
  output logic          o_fetch_valid,
  output rv_pkg::xlen_t o_fetch_pc,
  input  wire           i_fetch_ready,
  input  rv_pkg::inst_t i_fetch_inst,
  // commit port
  output logic          o_cmt_valid,
  output rv_pkg::xlen_t o_cmt_pc,
  output rv_pkg::inst_t o_cmt_inst,
  output rv_pkg::ridx_t o_cmt_rd,
  output logic          o_cmt_wen,
  output rv_pkg::xlen_t o_cmt_wdata
);
  import rv_pkg::*;

  logic  fetched;
  xlen_t if_pc;
  inst_t if_inst;
  ridx_t rs1;
  ridx_t rs2;
  xlen_t rs1_data;
  xlen_t rs2_data;
  ridx_t wb_rd;
  logic  wb_rd_wen;
  xlen_t wb_rd_wdata;
  logic  redirect;
  xlen_t redirect_pc;
  logic  retired;

  dec_ex_if u_dec_ex ();
  ex_wb_if  u_ex_wb ();

  rv_fetch u_fetch (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_fetch_ready (i_fetch_ready),
    .i_fetch_inst  (i_fetch_inst),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .i_retired     (retired),
    .o_fetch_valid (o_fetch_valid),
    .o_fetch_pc    (o_fetch_pc),
    .o_fetched     (fetched),
    .o_inst        (if_inst)
  );

  // fetched pc is the requested pc
  assign if_pc = o_fetch_pc;

  rv_decode u_decode (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_fetched  (fetched),
    .i_pc       (if_pc),
    .i_inst     (if_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .dec        (u_dec_ex)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_rd       (wb_rd),
    .i_rd_wen   (wb_rd_wen),
    .i_rd_wdata (wb_rd_wdata)
  );

  rv_execute u_execute (
    .clk           (clk),
    .i_rst         (i_rst),
    .dec           (u_dec_ex),
    .wb            (u_ex_wb),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  rv_writeback u_writeback (
    .clk         (clk),
    .i_rst       (i_rst),
    .wb          (u_ex_wb),
    .o_rd        (wb_rd),
    .o_rd_wen    (wb_rd_wen),
    .o_rd_wdata  (wb_rd_wdata),
    .o_retired   (retired),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt_pc    (o_cmt_pc),
    .o_cmt_inst  (o_cmt_inst),
    .o_cmt_rd    (o_cmt_rd),
    .o_cmt_wen   (o_cmt_wen),
    .o_cmt_wdata (o_cmt_wdata)
  );

endmodule

`default_nettype wire

/* dv/tb_rv_core.sv */
// rv64 core testbench
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core;

  // 2 + 22 alu, 4 x0/unknown, 6 control flow, 8 under back-pressure
  localparam int NUM_INSTS  = 42;
  localparam int MAX_CYCLES = 60 * NUM_INSTS + 200;
  localparam int PROG_WORDS = 1024;

  logic        clk;
  logic        i_rst;
  logic        o_fetch_valid;
  logic [63:0] o_fetch_pc;
  logic        i_fetch_ready;
  logic [31:0] i_fetch_inst;
  logic        o_cmt_valid;
  logic [63:0] o_cmt_pc;
  logic [31:0] o_cmt_inst;
  logic [4:0]  o_cmt_rd;
  logic        o_cmt_wen;
  logic [63:0] o_cmt_wdata;

  logic [31:0] prog [0:PROG_WORDS-1];
  logic [63:0] xreg [0:31];
  logic [63:0] model_pc;
  int          errors;
  int          cycles;
  int          max_delay;
  int          wait_left;
  int unsigned seed;

  rv_core DUT (
    .clk           (clk),
    .i_rst         (i_rst),
    .o_fetch_valid (o_fetch_valid),
    .o_fetch_pc    (o_fetch_pc),
    .i_fetch_ready (i_fetch_ready),
    .i_fetch_inst  (i_fetch_inst),
    .o_cmt_valid   (o_cmt_valid),
    .o_cmt_pc      (o_cmt_pc),
    .o_cmt_inst    (o_cmt_inst),
    .o_cmt_rd      (o_cmt_rd),
    .o_cmt_wen     (o_cmt_wen),
    .o_cmt_wdata   (o_cmt_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int word_index(input logic [63:0] pc);
    logic [63:0] offs;
    offs = pc - `RV_RESET_PC;
    return int'(offs[11:2]);
  endfunction

  // instruction memory answering a held request after a random delay
  always @(posedge clk) begin
    if (i_rst) begin
      i_fetch_ready <= 1'b0;
      wait_left     <= 0;
    end else if (i_fetch_ready) begin
      i_fetch_ready <= 1'b0;
    end else if (o_fetch_valid) begin
      if (wait_left == 0) begin
        i_fetch_ready <= 1'b1;
        i_fetch_inst  <= prog[word_index(o_fetch_pc)];
        wait_left     <= $urandom_range(max_delay, 0);
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  task automatic end_with_failure(input string why);
    errors++;
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
      end_with_failure("DUT output did not match the reference model");
    end
  endtask

  // places one instruction at the predicted pc and checks its commit
  task automatic issue(input logic [31:0] inst, input logic [4:0] rd, input logic wen,
                       input logic [63:0] wdata, input logic [63:0] next_pc);
    int lat;
    prog[word_index(model_pc)] = inst;
    do begin
      @(posedge clk);
      assert (!o_cmt_valid) else end_with_failure("commit seen with no instruction in flight");
      if (o_fetch_valid) begin
        expect_eq("o_fetch_pc", o_fetch_pc, model_pc);
      end
    end while (!(o_fetch_valid && i_fetch_ready));
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      assert (!o_fetch_valid) else end_with_failure("second fetch request before commit");
    end while (o_cmt_valid !== 1'b1 && lat < 8);
    expect_eq("commit latency", lat, 3);
    expect_eq("o_cmt_pc", o_cmt_pc, model_pc);
    expect_eq("o_cmt_inst", o_cmt_inst, inst);
    expect_eq("o_cmt_wen", o_cmt_wen, wen);
    if (wen) begin
      expect_eq("o_cmt_rd", o_cmt_rd, rd);
      expect_eq("o_cmt_wdata", o_cmt_wdata, wdata);
      xreg[rd] = wdata;
    end
    model_pc = next_pc;
  endtask

  task automatic do_op(input logic [6:0] f7, input logic [2:0] f3,
                       input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    a = xreg[rs1];
    b = xreg[rs2];
    case (f3)
      `RV_F3_ADD_SUB: res = (f7 == `RV_F7_SUB) ? a - b : a + b;
      `RV_F3_SLT:     res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      `RV_F3_XOR:     res = a ^ b;
      `RV_F3_OR:      res = a | b;
      default:        res = a & b;
    endcase
    issue({f7, rs2, rs1, f3, rd, `RV_OPC_OP}, rd, rd != 5'd0, res, model_pc + 64'd4);
  endtask

  task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    issue({imm, rs1, 3'b000, rd, `RV_OPC_OP_IMM}, rd, rd != 5'd0,
          xreg[rs1] + {{52{imm[11]}}, imm}, model_pc + 64'd4);
  endtask

  task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm);
    issue({imm, rd, `RV_OPC_LUI}, rd, rd != 5'd0, {{32{imm[19]}}, imm, 12'h000},
          model_pc + 64'd4);
  endtask

  task automatic do_jal(input logic [4:0] rd, input logic [20:0] off);
    issue({off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL}, rd, rd != 5'd0,
          model_pc + 64'd4, model_pc + {{43{off[20]}}, off});
  endtask

  task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [12:0] off);
    logic taken;
    taken = (xreg[rs1] == xreg[rs2]) ^ (f3 == `RV_F3_BNE);
    issue({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OPC_BRANCH}, 5'd0, 1'b0,
          64'd0, taken ? model_pc + {{51{off[12]}}, off} : model_pc + 64'd4);
  endtask

  task automatic check_reset;
    @(posedge clk);
    repeat (3) begin
      @(posedge clk);
      expect_eq("o_fetch_valid", o_fetch_valid, 1'b0);
      expect_eq("o_cmt_valid", o_cmt_valid, 1'b0);
    end
    i_rst <= 1'b0;
  endtask

  task automatic run_alu_sequence;
    do_addi(5'd10, 5'd0, 12'hfff);
    do_op(7'h00, `RV_F3_SLT, 5'd11, 5'd10, 5'd0);
    repeat (2) begin
      do_lui(5'd1, 20'($urandom));
      do_addi(5'd1, 5'd1, 12'($urandom));
      do_lui(5'd2, 20'($urandom));
      do_addi(5'd2, 5'd2, 12'($urandom));
      do_op(7'h00, `RV_F3_ADD_SUB, 5'd3, 5'd1, 5'd2);
      do_op(`RV_F7_SUB, `RV_F3_ADD_SUB, 5'd4, 5'd1, 5'd2);
      do_op(7'h00, `RV_F3_AND, 5'd5, 5'd1, 5'd2);
      do_op(7'h00, `RV_F3_OR, 5'd6, 5'd1, 5'd2);
      do_op(7'h00, `RV_F3_XOR, 5'd7, 5'd1, 5'd2);
      do_op(7'h00, `RV_F3_SLT, 5'd8, 5'd1, 5'd2);
      do_op(7'h00, `RV_F3_SLT, 5'd9, 5'd2, 5'd1);
    end
  endtask

  task automatic run_x0_and_unknown;
    do_addi(5'd0, 5'd1, 12'h005);
    do_addi(5'd12, 5'd0, 12'h000);
    do_op(7'h00, `RV_F3_ADD_SUB, 5'd13, 5'd0, 5'd1);
    // custom-0 opcode outside the subset
    issue({20'habcde, 5'd14, 7'b0001011}, 5'd0, 1'b0, 64'd0, model_pc + 64'd4);
  endtask

  task automatic run_control_flow;
    do_jal(5'd15, 21'd16);
    do_jal(5'd0, 21'd8);
    do_branch(`RV_F3_BEQ, 5'd1, 5'd1, 13'd12);
    do_branch(`RV_F3_BEQ, 5'd0, 5'd10, 13'd12);
    do_branch(`RV_F3_BNE, 5'd0, 5'd10, 13'h1ff8);
    do_branch(`RV_F3_BNE, 5'd3, 5'd3, 13'd20);
  endtask

  task automatic run_backpressure;
    max_delay = 5;
    repeat (8) begin
      do_addi(5'(16 + $urandom_range(15, 0)), 5'($urandom_range(31, 0)), 12'($urandom));
    end
  endtask

  // last redirect or pc+4 shows up on the fetch port
  task automatic check_next_fetch;
    do begin
      @(posedge clk);
    end while (o_fetch_valid !== 1'b1);
    expect_eq("o_fetch_pc", o_fetch_pc, model_pc);
  endtask

  initial begin
    logic [63:0] addr;
    seed = $urandom(32'h835a_2015);
    i_rst         = 1'b1;
    i_fetch_ready = 1'b0;
    i_fetch_inst  = 32'h0;
    errors        = 0;
    max_delay     = 0;
    model_pc      = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      xreg[i] = 64'd0;
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      addr    = `RV_RESET_PC + 64'(i) * 64'd4;
      prog[i] = {addr[31:7] ^ addr[24:0], 7'b0001011};
    end
    check_reset();
    run_alu_sequence();
    run_x0_and_unknown();
    run_control_flow();
    run_backpressure();
    check_next_fetch();
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a fetch or commit never arrived", cycles);
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_pipe_ifs.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
dv/tb_rv_core.sv
